//--- bus_defines.svh
`ifndef BUS_DEFINES_SVH
`define BUS_DEFINES_SVH

// ram byte address width, 4 KB by default
`define MEM_WIDTH 12
`define DATA_W 32

// top address byte per region
`define MEM_TAG 8'h00
`define UART_TAG 8'h7F

// uart register offsets
`define UART_RX_OFS 4'h0
`define UART_TX_OFS 4'h4
`define UART_STAT_OFS 4'h8
`define UART_CTRL_OFS 4'hC

`endif

//--- axi_pkg.sv
`default_nettype none

package axi_pkg;

   // axi response codes
   typedef enum logic [1:0] {
      OKAY   = 2'b00,
      EXOKAY = 2'b01,
      SLVERR = 2'b10,
      DECERR = 2'b11
   } resp_t;

   // passed through untouched
   typedef logic [2:0] prot_t;

endpackage

`default_nettype wire

//--- map_pkg.sv
`default_nettype none

`include "bus_defines.svh"

package map_pkg;

   // where a transaction goes
   typedef enum logic [1:0] {
      TGT_MEM,
      TGT_UART,
      TGT_NONE
   } target_t;

   typedef enum logic [3:0] {
      REG_RX   = `UART_RX_OFS,
      REG_TX   = `UART_TX_OFS,
      REG_STAT = `UART_STAT_OFS,
      REG_CTRL = `UART_CTRL_OFS
   } uart_reg_t;

endpackage

`default_nettype wire

//--- axi_lite_if.sv
`default_nettype none

`include "bus_defines.svh"

interface axi_lite_if #(parameter int ADDR_W = 32);
   import axi_pkg::*;

   logic [ADDR_W-1:0]       awaddr;
   prot_t                   awprot;
   logic                    awvalid;
   logic                    awready;
   logic [`DATA_W-1:0]      wdata;
   logic [(`DATA_W/8)-1:0]  wstrb;
   logic                    wvalid;
   logic                    wready;
   resp_t                   bresp;
   logic                    bvalid;
   logic                    bready;
   logic [ADDR_W-1:0]       araddr;
   prot_t                   arprot;
   logic                    arvalid;
   logic                    arready;
   logic [`DATA_W-1:0]      rdata;
   resp_t                   rresp;
   logic                    rvalid;
   logic                    rready;

   modport manager (
      output awaddr, awprot, awvalid, wdata, wstrb, wvalid, bready,
      output araddr, arprot, arvalid, rready,
      input  awready, wready, bresp, bvalid, arready, rdata, rresp, rvalid
   );

   modport subordinate (
      input  awaddr, awprot, awvalid, wdata, wstrb, wvalid, bready,
      input  araddr, arprot, arvalid, rready,
      output awready, wready, bresp, bvalid, arready, rdata, rresp, rvalid
   );

endinterface

`default_nettype wire

//--- axi_router.sv
`default_nettype none

`include "bus_defines.svh"

module axi_router (
   input  logic                   clk,
   input  logic                   rstn,
   input  logic [31:0]            awaddr,
   input  axi_pkg::prot_t         awprot,
   input  logic                   awvalid,
   output logic                   awready,
   input  logic [`DATA_W-1:0]     wdata,
   input  logic [(`DATA_W/8)-1:0] wstrb,
   input  logic                   wvalid,
   output logic                   wready,
   output axi_pkg::resp_t         bresp,
   output logic                   bvalid,
   input  logic                   bready,
   input  logic [31:0]            araddr,
   input  axi_pkg::prot_t         arprot,
   input  logic                   arvalid,
   output logic                   arready,
   output logic [`DATA_W-1:0]     rdata,
   output axi_pkg::resp_t         rresp,
   output logic                   rvalid,
   input  logic                   rready,
   axi_lite_if.manager            mem_bus,
   axi_lite_if.manager            uart_bus
);
   import axi_pkg::*;
   import map_pkg::*;

   typedef enum logic [1:0] {RD_IDLE, RD_ADDR, RD_DATA, RD_RESP} rd_state_t;
   typedef enum logic [1:0] {WR_IDLE, WR_REQ, WR_BRESP, WR_RESP} wr_state_t;

   function automatic target_t decode(input logic [31:0] addr);
      if (addr[31:24] == `MEM_TAG && addr[23:`MEM_WIDTH] == '0)
         return TGT_MEM;
      if (addr[31:24] == `UART_TAG)
         return TGT_UART;
      return TGT_NONE;
   endfunction

   rd_state_t               rd_state;
   target_t                 rd_tgt;
   target_t                 ar_tgt;
   logic [`MEM_WIDTH-1:0]   rd_addr;
   prot_t                   rd_prot;
   logic                    rd_req;
   logic                    rd_wait;
   logic                    t_arready;
   logic                    t_rvalid;
   logic [`DATA_W-1:0]      t_rdata;
   resp_t                   t_rresp;

   wr_state_t               wr_state;
   target_t                 wr_tgt;
   target_t                 aw_tgt;
   logic [`MEM_WIDTH-1:0]   wr_addr;
   prot_t                   wr_prot;
   logic [`DATA_W-1:0]      wr_data;
   logic [(`DATA_W/8)-1:0]  wr_strb;
   logic                    aw_req;
   logic                    w_req;
   logic                    wr_wait;
   logic                    t_awready;
   logic                    t_wready;
   logic                    t_bvalid;
   resp_t                   t_bresp;

   assign ar_tgt = decode(araddr);
   assign aw_tgt = decode(awaddr);

   // merge of the two targets
   assign t_arready = (rd_tgt == TGT_UART) ? uart_bus.arready : mem_bus.arready;
   assign t_rvalid  = (rd_tgt == TGT_UART) ? uart_bus.rvalid  : mem_bus.rvalid;
   assign t_rdata   = (rd_tgt == TGT_UART) ? uart_bus.rdata   : mem_bus.rdata;
   assign t_rresp   = (rd_tgt == TGT_UART) ? uart_bus.rresp   : mem_bus.rresp;
   assign t_awready = (wr_tgt == TGT_UART) ? uart_bus.awready : mem_bus.awready;
   assign t_wready  = (wr_tgt == TGT_UART) ? uart_bus.wready  : mem_bus.wready;
   assign t_bvalid  = (wr_tgt == TGT_UART) ? uart_bus.bvalid  : mem_bus.bvalid;
   assign t_bresp   = (wr_tgt == TGT_UART) ? uart_bus.bresp   : mem_bus.bresp;

   assign mem_bus.araddr   = rd_addr;
   assign mem_bus.arprot   = rd_prot;
   assign mem_bus.arvalid  = rd_req && (rd_tgt == TGT_MEM);
   assign mem_bus.rready   = rd_wait && (rd_tgt == TGT_MEM);
   assign mem_bus.awaddr   = wr_addr;
   assign mem_bus.awprot   = wr_prot;
   assign mem_bus.awvalid  = aw_req && (wr_tgt == TGT_MEM);
   assign mem_bus.wdata    = wr_data;
   assign mem_bus.wstrb    = wr_strb;
   assign mem_bus.wvalid   = w_req && (wr_tgt == TGT_MEM);
   assign mem_bus.bready   = wr_wait && (wr_tgt == TGT_MEM);

   // uart only sees the register offset
   assign uart_bus.araddr  = rd_addr[3:0];
   assign uart_bus.arprot  = rd_prot;
   assign uart_bus.arvalid = rd_req && (rd_tgt == TGT_UART);
   assign uart_bus.rready  = rd_wait && (rd_tgt == TGT_UART);
   assign uart_bus.awaddr  = wr_addr[3:0];
   assign uart_bus.awprot  = wr_prot;
   assign uart_bus.awvalid = aw_req && (wr_tgt == TGT_UART);
   assign uart_bus.wdata   = wr_data;
   assign uart_bus.wstrb   = wr_strb;
   assign uart_bus.wvalid  = w_req && (wr_tgt == TGT_UART);
   assign uart_bus.bready  = wr_wait && (wr_tgt == TGT_UART);

   //////////////////////////////////////////////////
   // read path

   always_ff @(posedge clk) begin
      if (rstn) begin
         rd_state <= RD_IDLE;
         rd_tgt   <= TGT_NONE;
         arready  <= 1'b1;
         rvalid   <= 1'b0;
         rd_req   <= 1'b0;
         rd_wait  <= 1'b0;
      end else begin
         case (rd_state)
            RD_IDLE: begin
               if (arvalid && arready) begin
                  arready <= 1'b0;
                  rd_tgt  <= ar_tgt;
                  rd_addr <= araddr[`MEM_WIDTH-1:0];
                  rd_prot <= arprot;
                  if (ar_tgt == TGT_NONE) begin
                     // unmapped, answer here
                     rdata    <= '0;
                     rresp    <= DECERR;
                     rvalid   <= 1'b1;
                     rd_state <= RD_RESP;
                  end else begin
                     rd_req   <= 1'b1;
                     rd_state <= RD_ADDR;
                  end
               end
            end
            RD_ADDR: begin
               if (t_arready) begin
                  rd_req   <= 1'b0;
                  rd_wait  <= 1'b1;
                  rd_state <= RD_DATA;
               end
            end
            RD_DATA: begin
               if (t_rvalid) begin
                  rd_wait  <= 1'b0;
                  rdata    <= t_rdata;
                  rresp    <= t_rresp;
                  rvalid   <= 1'b1;
                  rd_state <= RD_RESP;
               end
            end
            default: begin
               if (rready) begin
                  rvalid   <= 1'b0;
                  arready  <= 1'b1;
                  rd_state <= RD_IDLE;
               end
            end
         endcase
      end
   end

   //////////////////////////////////////////////////
   // write path

   always_ff @(posedge clk) begin
      if (rstn) begin
         wr_state <= WR_IDLE;
         wr_tgt   <= TGT_NONE;
         awready  <= 1'b1;
         wready   <= 1'b1;
         bvalid   <= 1'b0;
         aw_req   <= 1'b0;
         w_req    <= 1'b0;
         wr_wait  <= 1'b0;
      end else begin
         case (wr_state)
            WR_IDLE: begin
               if (awvalid && awready) begin
                  awready <= 1'b0;
                  wr_tgt  <= aw_tgt;
                  wr_addr <= awaddr[`MEM_WIDTH-1:0];
                  wr_prot <= awprot;
               end
               if (wvalid && wready) begin
                  wready  <= 1'b0;
                  wr_data <= wdata;
                  wr_strb <= wstrb;
               end
               // both halves held
               if (!awready && !wready) begin
                  if (wr_tgt == TGT_NONE) begin
                     bresp    <= DECERR;
                     bvalid   <= 1'b1;
                     wr_state <= WR_RESP;
                  end else begin
                     aw_req   <= 1'b1;
                     w_req    <= 1'b1;
                     wr_state <= WR_REQ;
                  end
               end
            end
            WR_REQ: begin
               if (t_awready)
                  aw_req <= 1'b0;
               if (t_wready)
                  w_req <= 1'b0;
               if (!aw_req && !w_req) begin
                  wr_wait  <= 1'b1;
                  wr_state <= WR_BRESP;
               end
            end
            WR_BRESP: begin
               if (t_bvalid) begin
                  wr_wait  <= 1'b0;
                  bresp    <= t_bresp;
                  bvalid   <= 1'b1;
                  wr_state <= WR_RESP;
               end
            end
            default: begin
               if (bready) begin
                  bvalid   <= 1'b0;
                  awready  <= 1'b1;
                  wready   <= 1'b1;
                  wr_state <= WR_IDLE;
               end
            end
         endcase
      end
   end

endmodule

`default_nettype wire

//--- axi_ram.sv
`default_nettype none

`include "bus_defines.svh"

module axi_ram (
   input  logic             clk,
   input  logic             rstn,
   axi_lite_if.subordinate  bus
);
   import axi_pkg::*;

   localparam int WORDS = 1 << (`MEM_WIDTH - 2);

   logic [`DATA_W-1:0]      mem [0:WORDS-1];
   logic                    aw_full;
   logic                    w_full;
   logic                    bvalid_q;
   logic                    rvalid_q;
   logic [`MEM_WIDTH-1:0]   awaddr_q;
   logic [`DATA_W-1:0]      wdata_q;
   logic [(`DATA_W/8)-1:0]  wstrb_q;
   logic [`DATA_W-1:0]      rdata_q;
   logic [`MEM_WIDTH-3:0]   wr_word;
   logic [`DATA_W-1:0]      wr_data;
   logic [(`DATA_W/8)-1:0]  wr_strb;
   logic                    aw_hs;
   logic                    w_hs;
   logic                    ar_hs;
   logic                    do_write;

   assign aw_hs = bus.awvalid && bus.awready;
   assign w_hs  = bus.wvalid && bus.wready;
   assign ar_hs = bus.arvalid && bus.arready;

   // write goes out on the later of the two handshakes
   assign do_write = (aw_full || aw_hs) && (w_full || w_hs);
   assign wr_word  = aw_full ? awaddr_q[`MEM_WIDTH-1:2] : bus.awaddr[`MEM_WIDTH-1:2];
   assign wr_data  = w_full ? wdata_q : bus.wdata;
   assign wr_strb  = w_full ? wstrb_q : bus.wstrb;

   assign bus.awready = !aw_full && !bvalid_q;
   assign bus.wready  = !w_full && !bvalid_q;
   assign bus.bvalid  = bvalid_q;
   assign bus.bresp   = OKAY;
   assign bus.arready = !rvalid_q;
   assign bus.rvalid  = rvalid_q;
   assign bus.rdata   = rdata_q;
   assign bus.rresp   = OKAY;

   always_ff @(posedge clk) begin
      if (rstn) begin
         aw_full  <= 1'b0;
         w_full   <= 1'b0;
         bvalid_q <= 1'b0;
         rvalid_q <= 1'b0;
      end else begin
         if (do_write) begin
            aw_full  <= 1'b0;
            w_full   <= 1'b0;
            bvalid_q <= 1'b1;
         end else begin
            if (aw_hs)
               aw_full <= 1'b1;
            if (w_hs)
               w_full <= 1'b1;
         end
         if (bvalid_q && bus.bready)
            bvalid_q <= 1'b0;
         if (ar_hs)
            rvalid_q <= 1'b1;
         else if (bus.rready)
            rvalid_q <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (aw_hs)
         awaddr_q <= bus.awaddr;
      if (w_hs) begin
         wdata_q <= bus.wdata;
         wstrb_q <= bus.wstrb;
      end
      if (do_write) begin
         for (int i = 0; i < `DATA_W / 8; i++)
            if (wr_strb[i])
               mem[wr_word][8*i +: 8] <= wr_data[8*i +: 8];
      end
      if (ar_hs)
         rdata_q <= mem[bus.araddr[`MEM_WIDTH-1:2]];
   end

endmodule

`default_nettype wire

//--- uart_regs.sv
`default_nettype none

`include "bus_defines.svh"

module uart_regs (
   input  logic             clk,
   input  logic             rstn,
   axi_lite_if.subordinate  bus,
   output logic [7:0]       tx_byte,
   output logic             tx_strobe,
   input  logic [7:0]       rx_byte,
   input  logic             rx_strobe
);
   import axi_pkg::*;
   import map_pkg::*;

   logic                    aw_full;
   logic                    w_full;
   logic                    bvalid_q;
   logic                    rvalid_q;
   resp_t                   bresp_q;
   resp_t                   rresp_q;
   logic [3:0]              awaddr_q;
   logic [`DATA_W-1:0]      wdata_q;
   logic [(`DATA_W/8)-1:0]  wstrb_q;
   logic [`DATA_W-1:0]      rdata_q;
   logic [`DATA_W-1:0]      wr_data;
   logic [(`DATA_W/8)-1:0]  wr_strb;
   uart_reg_t               wr_reg;
   uart_reg_t               rd_reg;
   logic                    aw_hs;
   logic                    w_hs;
   logic                    ar_hs;
   logic                    do_write;
   logic                    tx_write;
   logic                    rx_full;
   logic                    loopback;
   logic [7:0]              rx_data;

   assign aw_hs = bus.awvalid && bus.awready;
   assign w_hs  = bus.wvalid && bus.wready;
   assign ar_hs = bus.arvalid && bus.arready;

   assign do_write = (aw_full || aw_hs) && (w_full || w_hs);
   assign wr_reg   = uart_reg_t'(aw_full ? awaddr_q : bus.awaddr);
   assign rd_reg   = uart_reg_t'(bus.araddr);
   assign wr_data  = w_full ? wdata_q : bus.wdata;
   assign wr_strb  = w_full ? wstrb_q : bus.wstrb;
   assign tx_write = do_write && (wr_reg == REG_TX) && wr_strb[0];

   assign bus.awready = !aw_full && !bvalid_q;
   assign bus.wready  = !w_full && !bvalid_q;
   assign bus.bvalid  = bvalid_q;
   assign bus.bresp   = bresp_q;
   assign bus.arready = !rvalid_q;
   assign bus.rvalid  = rvalid_q;
   assign bus.rdata   = rdata_q;
   assign bus.rresp   = rresp_q;

   //////////////////////////////////////////////////
   // control state

   always_ff @(posedge clk) begin
      if (rstn) begin
         aw_full   <= 1'b0;
         w_full    <= 1'b0;
         bvalid_q  <= 1'b0;
         rvalid_q  <= 1'b0;
         tx_strobe <= 1'b0;
         loopback  <= 1'b0;
         rx_full   <= 1'b0;
      end else begin
         tx_strobe <= tx_write;
         if (do_write) begin
            aw_full  <= 1'b0;
            w_full   <= 1'b0;
            bvalid_q <= 1'b1;
            if (wr_reg == REG_CTRL && wr_strb[0])
               loopback <= wr_data[0];
         end else begin
            if (aw_hs)
               aw_full <= 1'b1;
            if (w_hs)
               w_full <= 1'b1;
         end
         if (bvalid_q && bus.bready)
            bvalid_q <= 1'b0;
         if (ar_hs)
            rvalid_q <= 1'b1;
         else if (bus.rready)
            rvalid_q <= 1'b0;
         // a new byte wins over a clearing read
         if (ar_hs && rd_reg == REG_RX)
            rx_full <= 1'b0;
         if (rx_strobe || (tx_write && loopback))
            rx_full <= 1'b1;
      end
   end

   //////////////////////////////////////////////////
   // payload

   always_ff @(posedge clk) begin
      if (aw_hs)
         awaddr_q <= bus.awaddr;
      if (w_hs) begin
         wdata_q <= bus.wdata;
         wstrb_q <= bus.wstrb;
      end
      if (tx_write)
         tx_byte <= wr_data[7:0];
      if (rx_strobe)
         rx_data <= rx_byte;
      else if (tx_write && loopback)
         rx_data <= wr_data[7:0];
      if (do_write) begin
         if (wr_reg == REG_TX || wr_reg == REG_CTRL)
            bresp_q <= OKAY;
         else
            bresp_q <= SLVERR;
      end
      if (ar_hs) begin
         case (rd_reg)
            REG_RX: begin
               rdata_q <= `DATA_W'(rx_data);
               rresp_q <= OKAY;
            end
            REG_STAT: begin
               // bit 0 rx full, bit 1 loopback
               rdata_q <= `DATA_W'({loopback, rx_full});
               rresp_q <= OKAY;
            end
            default: begin
               rdata_q <= '0;
               rresp_q <= SLVERR;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

//--- soc_bus_top.sv
`default_nettype none

`include "bus_defines.svh"

module soc_bus_top (
   input  logic                   clk,
   input  logic                   rstn,
   input  logic [31:0]            awaddr,
   input  axi_pkg::prot_t         awprot,
   input  logic                   awvalid,
   output logic                   awready,
   input  logic [`DATA_W-1:0]     wdata,
   input  logic [(`DATA_W/8)-1:0] wstrb,
   input  logic                   wvalid,
   output logic                   wready,
   output axi_pkg::resp_t         bresp,
   output logic                   bvalid,
   input  logic                   bready,
   input  logic [31:0]            araddr,
   input  axi_pkg::prot_t         arprot,
   input  logic                   arvalid,
   output logic                   arready,
   output logic [`DATA_W-1:0]     rdata,
   output axi_pkg::resp_t         rresp,
   output logic                   rvalid,
   input  logic                   rready,
   output logic [7:0]             tx_byte,
   output logic                   tx_strobe,
   input  logic [7:0]             rx_byte,
   input  logic                   rx_strobe
);

   axi_lite_if #(.ADDR_W(`MEM_WIDTH)) mem_bus ();
   axi_lite_if #(.ADDR_W(4))          uart_bus ();

   axi_router u_router (
      .clk      (clk),
      .rstn     (rstn),
      .awaddr   (awaddr),
      .awprot   (awprot),
      .awvalid  (awvalid),
      .awready  (awready),
      .wdata    (wdata),
      .wstrb    (wstrb),
      .wvalid   (wvalid),
      .wready   (wready),
      .bresp    (bresp),
      .bvalid   (bvalid),
      .bready   (bready),
      .araddr   (araddr),
      .arprot   (arprot),
      .arvalid  (arvalid),
      .arready  (arready),
      .rdata    (rdata),
      .rresp    (rresp),
      .rvalid   (rvalid),
      .rready   (rready),
      .mem_bus  (mem_bus.manager),
      .uart_bus (uart_bus.manager)
   );

   axi_ram u_ram (
      .clk  (clk),
      .rstn (rstn),
      .bus  (mem_bus.subordinate)
   );

   uart_regs u_uart (
      .clk       (clk),
      .rstn      (rstn),
      .bus       (uart_bus.subordinate),
      .tx_byte   (tx_byte),
      .tx_strobe (tx_strobe),
      .rx_byte   (rx_byte),
      .rx_strobe (rx_strobe)
   );

endmodule

`default_nettype wire

//--- tb_soc_bus.sv
`default_nettype none

`include "bus_defines.svh"

module tb_soc_bus;
   timeunit 1ns;
   timeprecision 1ps;
   import axi_pkg::*;

   typedef enum logic [1:0] {OP_READ, OP_WRITE, OP_RX} op_t;

   typedef struct packed {
      op_t          op;
      logic [31:0]  addr;
      logic [31:0]  data;
      logic [3:0]   strb;
      logic [31:0]  rdata;
      resp_t        resp;
      logic         tx;
   } entry_t;

   localparam int MAX_ENTRIES = 40;
   localparam logic [31:0] UART_BASE = {`UART_TAG, 24'h0};

   logic                    clk;
   logic                    rstn;
   logic [31:0]             awaddr;
   prot_t                   awprot;
   logic                    awvalid;
   logic                    awready;
   logic [`DATA_W-1:0]      wdata;
   logic [(`DATA_W/8)-1:0]  wstrb;
   logic                    wvalid;
   logic                    wready;
   resp_t                   bresp;
   logic                    bvalid;
   logic                    bready;
   logic [31:0]             araddr;
   prot_t                   arprot;
   logic                    arvalid;
   logic                    arready;
   logic [`DATA_W-1:0]      rdata;
   resp_t                   rresp;
   logic                    rvalid;
   logic                    rready;
   logic [7:0]              tx_byte;
   logic                    tx_strobe;
   logic [7:0]              rx_byte;
   logic                    rx_strobe;

   entry_t                  stim [0:MAX_ENTRIES-1];
   int                      n_entries;
   logic                    table_ready;
   int                      errors;
   int                      tx_count;
   logic [7:0]              tx_last;
   integer                  seed;
   logic [31:0]             ram_model [0:(1 << (`MEM_WIDTH - 2))-1];

   soc_bus_top UUT (
      .clk       (clk),
      .rstn      (rstn),
      .awaddr    (awaddr),
      .awprot    (awprot),
      .awvalid   (awvalid),
      .awready   (awready),
      .wdata     (wdata),
      .wstrb     (wstrb),
      .wvalid    (wvalid),
      .wready    (wready),
      .bresp     (bresp),
      .bvalid    (bvalid),
      .bready    (bready),
      .araddr    (araddr),
      .arprot    (arprot),
      .arvalid   (arvalid),
      .arready   (arready),
      .rdata     (rdata),
      .rresp     (rresp),
      .rvalid    (rvalid),
      .rready    (rready),
      .tx_byte   (tx_byte),
      .tx_strobe (tx_strobe),
      .rx_byte   (rx_byte),
      .rx_strobe (rx_strobe)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // count transmit pulses away from the active edge
   always @(negedge clk) begin
      if (tx_strobe === 1'b1) begin
         tx_count++;
         tx_last = tx_byte;
      end
   end

   //////////////////////////////////////////////////
   // helpers

   task check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
      assert (got === exp) else begin
         errors++;
         $display("mismatch %s: got %h expected %h", name, got, exp);
      end
   endtask

   task add_entry(input op_t op, input logic [31:0] addr, input logic [31:0] data,
                  input logic [3:0] strb, input logic [31:0] exp_rdata,
                  input resp_t exp_resp, input logic exp_tx);
      stim[n_entries] = {op, addr, data, strb, exp_rdata, exp_resp, exp_tx};
      n_entries++;
   endtask

   // aw and w may start apart and bready is held off at random
   task write_access(input logic [31:0] addr, input logic [31:0] data,
                     input logic [3:0] strb, output resp_t resp);
      int   cyc;
      int   aw_lag;
      int   w_lag;
      int   stall;
      logic aw_done;
      logic w_done;
      aw_lag = 0;
      w_lag  = 0;
      if ($random(seed) & 1)
         w_lag = $unsigned($random(seed)) % 3;
      else
         aw_lag = $unsigned($random(seed)) % 3;
      stall   = $unsigned($random(seed)) % 4;
      awaddr  <= addr;
      wdata   <= data;
      wstrb   <= strb;
      awvalid <= (aw_lag == 0);
      wvalid  <= (w_lag == 0);
      cyc     = 0;
      aw_done = 1'b0;
      w_done  = 1'b0;
      while (!(aw_done && w_done)) begin
         @(posedge clk);
         cyc++;
         if (awvalid && awready) begin
            aw_done = 1'b1;
            awvalid <= 1'b0;
         end
         if (wvalid && wready) begin
            w_done = 1'b1;
            wvalid <= 1'b0;
         end
         if (!aw_done && cyc == aw_lag)
            awvalid <= 1'b1;
         if (!w_done && cyc == w_lag)
            wvalid <= 1'b1;
      end
      do @(posedge clk); while (!bvalid);
      repeat (stall) @(posedge clk);
      bready <= 1'b1;
      do @(posedge clk); while (!bvalid);
      resp = bresp;
      bready <= 1'b0;
   endtask

   task read_access(input logic [31:0] addr, output logic [31:0] data, output resp_t resp);
      int stall;
      stall   = $unsigned($random(seed)) % 4;
      araddr  <= addr;
      arvalid <= 1'b1;
      do @(posedge clk); while (!arready);
      arvalid <= 1'b0;
      do @(posedge clk); while (!rvalid);
      repeat (stall) @(posedge clk);
      rready <= 1'b1;
      do @(posedge clk); while (!rvalid);
      data = rdata;
      resp = rresp;
      rready <= 1'b0;
   endtask

   task rx_inject(input logic [7:0] value);
      rx_byte   <= value;
      rx_strobe <= 1'b1;
      @(posedge clk);
      rx_strobe <= 1'b0;
      @(posedge clk);
   endtask

   //////////////////////////////////////////////////
   // stimulus table

   task build_table();
      // ram with full and partial strobes
      add_entry(OP_WRITE, 32'h0000_0010, 32'h1122_3344, 4'hF, 32'h0, OKAY, 1'b0);
      add_entry(OP_WRITE, 32'h0000_0014, 32'hAABB_CCDD, 4'hF, 32'h0, OKAY, 1'b0);
      add_entry(OP_READ,  32'h0000_0010, 32'h0, 4'h0, 32'h1122_3344, OKAY, 1'b0);
      add_entry(OP_WRITE, 32'h0000_0010, 32'h5566_7788, 4'h5, 32'h0, OKAY, 1'b0);
      add_entry(OP_READ,  32'h0000_0010, 32'h0, 4'h0, 32'h1166_3388, OKAY, 1'b0);
      add_entry(OP_WRITE, 32'h0000_0014, 32'h0000_EE00, 4'h2, 32'h0, OKAY, 1'b0);
      add_entry(OP_READ,  32'h0000_0014, 32'h0, 4'h0, 32'hAABB_EEDD, OKAY, 1'b0);
      add_entry(OP_WRITE, 32'h0000_0FFC, 32'hCAFE_F00D, 4'hF, 32'h0, OKAY, 1'b0);
      add_entry(OP_READ,  32'h0000_0FFC, 32'h0, 4'h0, 32'hCAFE_F00D, OKAY, 1'b0);
      // the first unmapped write would alias word 0x010 if forwarded
      add_entry(OP_WRITE, 32'h0000_1010, 32'hDEAD_BEEF, 4'hF, 32'h0, DECERR, 1'b0);
      add_entry(OP_READ,  32'h0000_1010, 32'h0, 4'h0, 32'h0, DECERR, 1'b0);
      add_entry(OP_WRITE, 32'h1000_0010, 32'hDEAD_BEEF, 4'hF, 32'h0, DECERR, 1'b0);
      add_entry(OP_READ,  32'h8000_0000, 32'h0, 4'h0, 32'h0, DECERR, 1'b0);
      add_entry(OP_READ,  32'h0000_0010, 32'h0, 4'h0, 32'h1166_3388, OKAY, 1'b0);
      // uart transmit and receive
      add_entry(OP_WRITE, UART_BASE | `UART_TX_OFS, 32'h5A, 4'h1, 32'h0, OKAY, 1'b1);
      add_entry(OP_READ,  UART_BASE | `UART_STAT_OFS, 32'h0, 4'h0, 32'h0, OKAY, 1'b0);
      add_entry(OP_RX,    32'h0, 32'hC3, 4'h0, 32'h0, OKAY, 1'b0);
      add_entry(OP_READ,  UART_BASE | `UART_STAT_OFS, 32'h0, 4'h0, 32'h1, OKAY, 1'b0);
      add_entry(OP_READ,  UART_BASE | `UART_RX_OFS, 32'h0, 4'h0, 32'hC3, OKAY, 1'b0);
      add_entry(OP_READ,  UART_BASE | `UART_STAT_OFS, 32'h0, 4'h0, 32'h0, OKAY, 1'b0);
      // loopback on
      add_entry(OP_WRITE, UART_BASE | `UART_CTRL_OFS, 32'h1, 4'h1, 32'h0, OKAY, 1'b0);
      add_entry(OP_READ,  UART_BASE | `UART_STAT_OFS, 32'h0, 4'h0, 32'h2, OKAY, 1'b0);
      add_entry(OP_WRITE, UART_BASE | `UART_TX_OFS, 32'h1234_56A7, 4'h1, 32'h0, OKAY, 1'b1);
      add_entry(OP_READ,  UART_BASE | `UART_STAT_OFS, 32'h0, 4'h0, 32'h3, OKAY, 1'b0);
      add_entry(OP_READ,  UART_BASE | `UART_RX_OFS, 32'h0, 4'h0, 32'hA7, OKAY, 1'b0);
      add_entry(OP_READ,  UART_BASE | `UART_STAT_OFS, 32'h0, 4'h0, 32'h2, OKAY, 1'b0);
      // wrong direction and bad offsets
      add_entry(OP_READ,  UART_BASE | `UART_TX_OFS, 32'h0, 4'h0, 32'h0, SLVERR, 1'b0);
      add_entry(OP_WRITE, UART_BASE | `UART_RX_OFS, 32'h77, 4'h1, 32'h0, SLVERR, 1'b0);
      add_entry(OP_WRITE, UART_BASE | `UART_STAT_OFS, 32'h77, 4'h1, 32'h0, SLVERR, 1'b0);
      add_entry(OP_READ,  UART_BASE | `UART_CTRL_OFS, 32'h0, 4'h0, 32'h0, SLVERR, 1'b0);
      add_entry(OP_READ,  UART_BASE | 32'h6, 32'h0, 4'h0, 32'h0, SLVERR, 1'b0);
      // no lane 0 so nothing goes out
      add_entry(OP_WRITE, UART_BASE | `UART_TX_OFS, 32'h0000_9900, 4'h2, 32'h0, OKAY, 1'b0);
   endtask

   //////////////////////////////////////////////////
   // main sequence

   initial begin
      entry_t      e;
      resp_t       resp;
      logic [31:0] data;
      int          tx_before;
      rstn        = 1'b1;
      awaddr      = '0;
      awprot      = '0;
      awvalid     = 1'b0;
      wdata       = '0;
      wstrb       = '0;
      wvalid      = 1'b0;
      bready      = 1'b0;
      araddr      = '0;
      arprot      = '0;
      arvalid     = 1'b0;
      rready      = 1'b0;
      rx_byte     = '0;
      rx_strobe   = 1'b0;
      errors      = 0;
      tx_count    = 0;
      n_entries   = 0;
      seed        = 32'ha0b0;
      table_ready = 1'b0;
      build_table();
      table_ready = 1'b1;
      repeat (10) @(posedge clk);
      rstn <= 1'b0;
      @(posedge clk);
      // readies high and valids low
      check_value("ready/valid after reset", {awready, wready, arready, bvalid, rvalid},
                  32'h1C);
      for (int i = 0; i < n_entries; i++) begin
         e = stim[i];
         tx_before = tx_count;
         case (e.op)
            OP_WRITE: begin
               write_access(e.addr, e.data, e.strb, resp);
               check_value("bresp", {30'd0, resp}, {30'd0, e.resp});
               if (e.resp == OKAY && e.addr[31:24] == `MEM_TAG) begin
                  for (int b = 0; b < 4; b++)
                     if (e.strb[b])
                        ram_model[e.addr[`MEM_WIDTH-1:2]][8*b +: 8] = e.data[8*b +: 8];
               end
            end
            OP_READ: begin
               read_access(e.addr, data, resp);
               check_value("rdata", data, e.rdata);
               check_value("rresp", {30'd0, resp}, {30'd0, e.resp});
               if (e.resp == OKAY && e.addr[31:24] == `MEM_TAG)
                  check_value("rdata vs ram model", data, ram_model[e.addr[`MEM_WIDTH-1:2]]);
            end
            default: begin
               rx_inject(e.data[7:0]);
            end
         endcase
         check_value("tx_strobe count", tx_count - tx_before, {31'd0, e.tx});
         if (e.tx)
            check_value("tx_byte", {24'd0, tx_last}, {24'd0, e.data[7:0]});
      end
      $display("%0d errors after %0d table entries", errors, n_entries);
      if (errors == 0)
         $display("Test completed successfully");
      else
         $display("Test failed");
      $finish;
   end

   // run limit scales with the table length
   initial begin
      wait (table_ready);
      repeat (10 + n_entries * 40) @(posedge clk);
      $display("watchdog expired before all table entries completed");
      $display("Test failed");
      $finish;
   end

endmodule

`default_nettype wire

//--- sources.f
+incdir+.
axi_pkg.sv
map_pkg.sv
axi_lite_if.sv
axi_router.sv
axi_ram.sv
uart_regs.sv
soc_bus_top.sv
tb_soc_bus.sv
